// File: logic/vector_pkg.sv
package vector_pkg;

    parameter int XLEN        = 32;
    parameter int NUM_VREGS   = 32;
    parameter int VREG_ADDR_W = 5;

    // Instruction class from the scalar decoder
    typedef enum logic [2:0] {
        I_NONE,
        VECTOR,
        VSETVL,
        VSETVLI,
        VSETIVLI
    } instr_class_e;

    typedef enum logic [3:0] {
        V_NOP,
        V_AND,
        V_OR,
        V_XOR,
        V_ADD,
        V_SUB,
        V_SLL,
        V_SRL,
        V_SRA,
        V_MIN,
        V_MINU,
        V_MAX,
        V_MAXU
    } vector_op_e;

    // funct3 encodings of the integer categories
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    // Codes above EW32 are reserved
    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vsew_e;

    // Fractional and reserved codes are not listed
    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_DRAIN
    } seq_state_e;

    ////////////////////
    // Instruction word
    ////////////////////

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } varith_t;

    // Bits 31:30 carry the vsetvl and vsetivli prefixes
    typedef struct packed {
        logic [1:0] top;
        logic [9:0] zimm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vset_t;

    typedef union packed {
        varith_t arith;
        vset_t   vset;
    } vinstr_u;

endpackage

// File: logic/vector_ifs.sv
// Current vtype and vl
interface vcfg_if #(
    parameter int VLEN = 64
);
    import vector_pkg::*;

    localparam int VL_W = $clog2(VLEN + 1);

    vsew_e           sew;
    vlmul_e          lmul;
    logic [VL_W-1:0] vl;
    logic            vill;

    modport csr (output sew, lmul, vl, vill);
    modport user (input sew, lmul, vl, vill);
endinterface

// One register step of a group, issued every cycle with no back-pressure
interface vstep_if;
    import vector_pkg::*;

    logic                   issue;
    logic [2:0]             step_idx;
    logic [VREG_ADDR_W-1:0] vd_addr;
    vector_op_e             op;
    op_cat_e                op_cat;
    logic [4:0]             simm5;
    logic [XLEN-1:0]        scalar;

    modport seq (output issue, step_idx, vd_addr, op, op_cat, simm5, scalar);
    modport alu (input issue, step_idx, vd_addr, op, op_cat, simm5, scalar);
endinterface

// Two combinational read ports of the register file
interface vreg_read_if #(
    parameter int VLEN = 64
);
    import vector_pkg::*;

    logic [VREG_ADDR_W-1:0] vs1_addr;
    logic [VREG_ADDR_W-1:0] vs2_addr;
    logic [VLEN-1:0]        vs1_data;
    logic [VLEN-1:0]        vs2_data;

    modport seq (output vs1_addr, vs2_addr);
    modport rf (input vs1_addr, vs2_addr, output vs1_data, vs2_data);
    modport alu (input vs1_data, vs2_data);
endinterface

// File: logic/vector_csr.sv
module vector_csr #(
    parameter int VLEN = 64
) (
    input  logic                           clk,
    input  logic                           reset,
    input  vector_pkg::vinstr_u            instruction_i,
    input  vector_pkg::instr_class_e       instruction_operation_i,
    input  logic [vector_pkg::XLEN-1:0]    op1_scalar_i,
    input  logic [vector_pkg::XLEN-1:0]    op2_scalar_i,
    input  logic [vector_pkg::XLEN-1:0]    result_lo_i,
    vcfg_if.csr                            cfg,
    output logic [vector_pkg::XLEN-1:0]    res_scalar_o,
    output logic                           wr_en_scalar_o
);
    import vector_pkg::*;

    localparam int VLENB = VLEN / 8;
    localparam int VL_W  = $clog2(VLEN + 1);

    logic            is_vset;
    logic [2:0]      sew_raw;
    logic [2:0]      lmul_raw;
    logic            vill_next;
    vsew_e           sew_next;
    vlmul_e          lmul_next;
    logic [VL_W-1:0] vlmax;
    logic [VL_W-1:0] vl_next;
    logic            rd_zero;
    logic            rs1_zero;

    assign is_vset  = instruction_operation_i inside {VSETVL, VSETVLI, VSETIVLI};
    assign rd_zero  = (instruction_i.vset.rd == '0);
    assign rs1_zero = (instruction_i.vset.rs1 == '0);

    ////////////////////
    // New vtype
    ////////////////////

    always_comb begin
        if (instruction_operation_i == VSETVL) begin
            sew_raw   = op2_scalar_i[5:3];
            lmul_raw  = op2_scalar_i[2:0];
            vill_next = op2_scalar_i[XLEN-1];
        end else begin
            sew_raw   = instruction_i.vset.zimm[5:3];
            lmul_raw  = instruction_i.vset.zimm[2:0];
            vill_next = 1'b0;
        end

        // SEW 64 and up, fractional and reserved LMUL
        if (sew_raw > 3'd2 || lmul_raw > 3'd3) begin
            vill_next = 1'b1;
        end

        // Illegal vtype stores as zero apart from vill
        sew_next  = vill_next ? EW8 : vsew_e'(sew_raw);
        lmul_next = vill_next ? LMUL_1 : vlmul_e'(lmul_raw);

        vlmax = VL_W'(VLENB >> sew_next) << lmul_next;
    end

    ////////////////////
    // New vl
    ////////////////////

    always_comb begin
        if (instruction_operation_i == VSETIVLI) begin
            vl_next = VL_W'(instruction_i.vset.rs1);
        end else if (!rd_zero && rs1_zero) begin
            vl_next = vlmax;
        end else if (rd_zero && rs1_zero) begin
            vl_next = cfg.vl;
        end else if (op1_scalar_i < XLEN'(vlmax)) begin
            vl_next = VL_W'(op1_scalar_i);
        end else begin
            vl_next = vlmax;
        end

        if (vill_next) begin
            vl_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.sew  <= EW8;
            cfg.lmul <= LMUL_1;
            cfg.vl   <= '0;
            cfg.vill <= 1'b0;
        end else if (is_vset) begin
            cfg.sew  <= sew_next;
            cfg.lmul <= lmul_next;
            cfg.vl   <= vl_next;
            cfg.vill <= vill_next;
        end
    end

    // Scalar writeback to the core
    always_comb begin
        if (is_vset) begin
            res_scalar_o   = XLEN'(vl_next);
            wr_en_scalar_o = 1'b1;
        end else if (instruction_operation_i == VECTOR) begin
            res_scalar_o   = result_lo_i;
            wr_en_scalar_o = 1'b0;
        end else begin
            res_scalar_o   = '0;
            wr_en_scalar_o = 1'b0;
        end
    end

endmodule

// File: logic/vector_sequencer.sv
module vector_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  vector_pkg::vinstr_u            instruction_i,
    input  vector_pkg::instr_class_e       instruction_operation_i,
    input  vector_pkg::vector_op_e         vector_operation_i,
    input  logic [vector_pkg::XLEN-1:0]    op1_scalar_i,
    vcfg_if.user                           cfg,
    vstep_if.seq                           step,
    vreg_read_if.seq                       rd,
    output logic                           hold_o
);
    import vector_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    logic [3:0] cnt;
    logic [3:0] group_len;
    logic [2:0] g;
    logic       start;

    // Registers in the group
    assign group_len = 4'd1 << cfg.lmul;

    assign start = (state == S_IDLE) && (instruction_operation_i == VECTOR);

    always_comb begin
        case (state)
            S_IDLE:  next_state = start ? S_EXEC : S_IDLE;
            S_EXEC:  next_state = (cnt < group_len) ? S_EXEC : S_DRAIN;
            S_DRAIN: next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            if (start) begin
                cnt <= 4'd1;
            end else if (state == S_EXEC) begin
                cnt <= cnt + 4'd1;
            end else begin
                cnt <= '0;
            end
        end
    end

    // Drain cycle lets the last write land with hold released
    assign hold_o = (instruction_operation_i == VECTOR) && (next_state != S_IDLE);

    ////////////////////
    // Step issue
    ////////////////////

    // Step 0 goes out in the idle cycle itself
    assign g = (state == S_EXEC) ? cnt[2:0] : 3'd0;

    assign rd.vs1_addr = instruction_i.arith.vs1 + {2'b00, g};
    assign rd.vs2_addr = instruction_i.arith.vs2 + {2'b00, g};

    assign step.issue    = start || ((state == S_EXEC) && (cnt < group_len));
    assign step.step_idx = g;
    assign step.vd_addr  = instruction_i.arith.vd + {2'b00, g};
    assign step.op       = vector_operation_i;
    assign step.op_cat   = op_cat_e'(instruction_i.arith.funct3);
    assign step.simm5    = instruction_i.arith.vs1;
    assign step.scalar   = op1_scalar_i;

endmodule

// File: logic/vector_regfile.sv
module vector_regfile #(
    parameter int VLEN = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    vreg_read_if.rf                              rd,
    input  logic [VLEN/8-1:0]                    wr_be_i,
    input  logic [vector_pkg::VREG_ADDR_W-1:0]   wr_addr_i,
    input  logic [VLEN-1:0]                      wr_data_i
);
    import vector_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [VLEN-1:0] regs [NUM_VREGS];

    assign rd.vs1_data = regs[rd.vs1_addr];
    assign rd.vs2_data = regs[rd.vs2_addr];

    // v0 holds the mask and is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_addr_i != '0) begin
            for (int b = 0; b < VLENB; b++) begin
                if (wr_be_i[b]) begin
                    regs[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: logic/vector_alu.sv
module vector_alu #(
    parameter int VLEN = 64
) (
    input  logic                                 clk,
    input  logic                                 reset,
    vcfg_if.user                                 cfg,
    vstep_if.alu                                 step,
    vreg_read_if.alu                             rd,
    output logic [VLEN/8-1:0]                    wr_be_o,
    output logic [vector_pkg::VREG_ADDR_W-1:0]   wr_addr_o,
    output logic [VLEN-1:0]                      wr_data_o,
    output logic [vector_pkg::XLEN-1:0]          result_lo_o
);
    import vector_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [XLEN-1:0]        imm_ext;
    logic [XLEN-1:0]        opb_src;
    logic [VLEN-1:0]        opb_rep;
    logic [VLEN-1:0]        opa;
    logic [VLEN-1:0]        opb;
    vector_op_e             op_q;
    logic [2:0]             g_q;
    logic [VREG_ADDR_W-1:0] vd_q;
    logic                   valid_q;
    logic [2:0][VLEN-1:0]   res_w;
    logic [VLEN-1:0]        lane_res;
    logic [VLENB-1:0]       be_next;

    ////////////////////
    // Operand stage
    ////////////////////

    always_comb begin
        // Shift immediates are unsigned
        if (step.op inside {V_SLL, V_SRL, V_SRA}) begin
            imm_ext = {{(XLEN-5){1'b0}}, step.simm5};
        end else begin
            imm_ext = {{(XLEN-5){step.simm5[4]}}, step.simm5};
        end

        opb_src = (step.op_cat == OPIVI) ? imm_ext : step.scalar;

        case (cfg.sew)
            EW8:     opb_rep = {(VLENB){opb_src[7:0]}};
            EW16:    opb_rep = {(VLENB/2){opb_src[15:0]}};
            default: opb_rep = {(VLENB/4){opb_src[31:0]}};
        endcase
    end

    always_ff @(posedge clk) begin
        opa  <= rd.vs2_data;
        opb  <= (step.op_cat == OPIVV) ? rd.vs1_data : opb_rep;
        op_q <= step.op;
        g_q  <= step.step_idx;
        vd_q <= step.vd_addr;
    end

    ////////////////////
    // Lanes
    ////////////////////

    // One lane set per element width and SEW picks the live one
    for (genvar w = 0; w < 3; w++) begin : g_sew
        localparam int EW = 8 << w;

        for (genvar i = 0; i < VLEN / EW; i++) begin : g_lane
            logic [EW-1:0] a;
            logic [EW-1:0] b;
            logic [EW-1:0] sum;
            logic [EW-1:0] res;
            logic [w+2:0]  shamt;
            logic          lt_s;
            logic          lt_u;

            assign a     = opa[i*EW +: EW];
            assign b     = opb[i*EW +: EW];
            assign shamt = b[w+2:0];
            assign sum   = (op_q == V_SUB) ? a + (~b + 1'b1) : a + b;
            assign lt_s  = $signed(a) < $signed(b);
            assign lt_u  = a < b;

            always_comb begin
                case (op_q)
                    V_AND:        res = a & b;
                    V_OR:         res = a | b;
                    V_XOR:        res = a ^ b;
                    V_ADD, V_SUB: res = sum;
                    V_SLL:        res = a << shamt;
                    V_SRL:        res = a >> shamt;
                    V_SRA:        res = $signed(a) >>> shamt;
                    V_MIN:        res = lt_s ? a : b;
                    V_MINU:       res = lt_u ? a : b;
                    V_MAX:        res = lt_s ? b : a;
                    V_MAXU:       res = lt_u ? b : a;
                    default:      res = '0;
                endcase
            end

            assign res_w[w][i*EW +: EW] = res;
        end
    end

    always_comb begin
        case (cfg.sew)
            EW8:     lane_res = res_w[0];
            EW16:    lane_res = res_w[1];
            default: lane_res = res_w[2];
        endcase
    end

    // Element index runs across the whole group
    always_comb begin
        for (int b = 0; b < VLENB; b++) begin
            be_next[b] = valid_q && !cfg.vill &&
                         ((int'(g_q) * (VLENB >> cfg.sew)) + (b >> cfg.sew) < int'(cfg.vl));
        end
    end

    ////////////////////
    // Result stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            wr_be_o <= '0;
        end else begin
            valid_q <= step.issue;
            wr_be_o <= be_next;
        end
    end

    always_ff @(posedge clk) begin
        wr_data_o <= lane_res;
        wr_addr_o <= vd_q;
    end

    // Unmasked result for the scalar port
    assign result_lo_o = wr_data_o[XLEN-1:0];

endmodule

// File: logic/vector_unit.sv
module vector_unit #(
    parameter int VLEN = 64
) (
    input  logic                           clk,
    input  logic                           reset,

    input  logic [31:0]                    instruction_i,
    input  vector_pkg::instr_class_e       instruction_operation_i,
    input  vector_pkg::vector_op_e         vector_operation_i,

    input  logic [vector_pkg::XLEN-1:0]    op1_scalar_i,
    input  logic [vector_pkg::XLEN-1:0]    op2_scalar_i,

    output logic                           hold_o,

    output logic [vector_pkg::XLEN-1:0]    res_scalar_o,
    output logic                           wr_en_scalar_o
);
    import vector_pkg::*;

    logic [VLEN/8-1:0]      wr_be;
    logic [VREG_ADDR_W-1:0] wr_addr;
    logic [VLEN-1:0]        wr_data;
    logic [XLEN-1:0]        result_lo;

    vcfg_if #(.VLEN(VLEN))      cfg_bus ();
    vstep_if                    step_bus ();
    vreg_read_if #(.VLEN(VLEN)) rd_bus ();

    vector_csr #(.VLEN(VLEN)) u_csr (
        .clk                     (clk),
        .reset                   (reset),
        .instruction_i           (instruction_i),
        .instruction_operation_i (instruction_operation_i),
        .op1_scalar_i            (op1_scalar_i),
        .op2_scalar_i            (op2_scalar_i),
        .result_lo_i             (result_lo),
        .cfg                     (cfg_bus),
        .res_scalar_o            (res_scalar_o),
        .wr_en_scalar_o          (wr_en_scalar_o)
    );

    vector_sequencer u_sequencer (
        .clk                     (clk),
        .reset                   (reset),
        .instruction_i           (instruction_i),
        .instruction_operation_i (instruction_operation_i),
        .vector_operation_i      (vector_operation_i),
        .op1_scalar_i            (op1_scalar_i),
        .cfg                     (cfg_bus),
        .step                    (step_bus),
        .rd                      (rd_bus),
        .hold_o                  (hold_o)
    );

    vector_regfile #(.VLEN(VLEN)) u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd        (rd_bus),
        .wr_be_i   (wr_be),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data)
    );

    vector_alu #(.VLEN(VLEN)) u_alu (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg_bus),
        .step        (step_bus),
        .rd          (rd_bus),
        .wr_be_o     (wr_be),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .result_lo_o (result_lo)
    );

endmodule

// File: dv/tb_vector_unit.sv
module tb_vector_unit;
    import vector_pkg::*;

    localparam int DRIVE_DLY  = 10;
    localparam int MAX_WAIT   = 20;
    localparam int NUM_RANDOM = 300;

    logic            clk;
    logic            reset;
    logic [31:0]     instruction_i;
    instr_class_e    instruction_operation_i;
    vector_op_e      vector_operation_i;
    logic [XLEN-1:0] op1_scalar_i;
    logic [XLEN-1:0] op2_scalar_i;
    logic            hold_o;
    logic [XLEN-1:0] res_scalar_o;
    logic            wr_en_scalar_o;

    // Reference state
    logic [31:0] m_regs [NUM_VREGS];
    int          m_vl;
    int          m_sew;
    int          m_lmul;
    bit          m_vill;
    logic [31:0] lcg_state;

    vector_unit #(.VLEN(32)) DUT (
        .clk                     (clk),
        .reset                   (reset),
        .instruction_i           (instruction_i),
        .instruction_operation_i (instruction_operation_i),
        .vector_operation_i      (vector_operation_i),
        .op1_scalar_i            (op1_scalar_i),
        .op2_scalar_i            (op2_scalar_i),
        .hold_o                  (hold_o),
        .res_scalar_o            (res_scalar_o),
        .wr_en_scalar_o          (wr_en_scalar_o)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "timeout");
    endtask

    // Scalar or immediate copied into every element
    function automatic logic [31:0] replicate(input logic [31:0] val, input int sw);
        case (sw)
            0:       return {4{val[7:0]}};
            1:       return {2{val[15:0]}};
            default: return val;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input vector_op_e op, input logic [31:0] a,
                                            input logic [31:0] b, input int sw);
        int                 ew;
        int                 e;
        int                 sh;
        logic [31:0]        m;
        logic [31:0]        x;
        logic [31:0]        y;
        logic [31:0]        r;
        logic [31:0]        res;
        logic signed [31:0] xs;
        logic signed [31:0] ys;
        ew  = 8 << sw;
        m   = (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
        res = '0;
        for (e = 0; e < 32 / ew; e++) begin
            x  = (a >> (e * ew)) & m;
            y  = (b >> (e * ew)) & m;
            xs = $signed(x << (32 - ew)) >>> (32 - ew);
            ys = $signed(y << (32 - ew)) >>> (32 - ew);
            sh = int'(y % ew);
            case (op)
                V_AND:   r = x & y;
                V_OR:    r = x | y;
                V_XOR:   r = x ^ y;
                V_ADD:   r = x + y;
                V_SUB:   r = x - y;
                V_SLL:   r = x << sh;
                V_SRL:   r = x >> sh;
                V_SRA:   r = 32'(xs >>> sh);
                V_MIN:   r = (xs < ys) ? x : y;
                V_MINU:  r = (x < y) ? x : y;
                V_MAX:   r = (xs < ys) ? y : x;
                V_MAXU:  r = (x < y) ? y : x;
                default: r = '0;
            endcase
            res = res | ((r & m) << (e * ew));
        end
        return res;
    endfunction

    function automatic bit groups_overlap(input int a, input int b, input int len);
        int d;
        d = (a - b + 32) % 32;
        return (d < len) || (d > 32 - len);
    endfunction

    // First destination group clear of the source groups modulo 32
    function automatic logic [4:0] pick_vd(input int vs2, input int vs1, input bit use_vs1,
                                           input int len, input int start);
        int         k;
        int         cand;
        bit         found;
        logic [4:0] pick;
        found = 0;
        pick  = '0;
        for (k = 0; k < 32; k++) begin
            cand = (start + k) % 32;
            if (!found && !groups_overlap(cand, vs2, len) &&
                !(use_vs1 && groups_overlap(cand, vs1, len))) begin
                pick  = 5'(cand);
                found = 1;
            end
        end
        return pick;
    endfunction

    ////////////////////
    // Instructions
    ////////////////////

    task automatic set_vtype(input instr_class_e kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [2:0] sew_raw,
                             input logic [2:0] lmul_raw, input logic [31:0] avl,
                             input bit bad_bit);
        bit         ill;
        int         ns;
        int         nl;
        int         vlmax;
        int         nvl;
        logic [1:0] top;
        ill = (kind == VSETVL) && bad_bit;
        if (sew_raw > 3'd2 || lmul_raw > 3'd3) begin
            ill = 1;
        end
        ns    = ill ? 0 : int'(sew_raw);
        nl    = ill ? 0 : int'(lmul_raw);
        vlmax = (4 >> ns) << nl;
        if (kind == VSETIVLI) begin
            nvl = int'(rs1);
        end else if (rd != 0 && rs1 == 0) begin
            nvl = vlmax;
        end else if (rd == 0 && rs1 == 0) begin
            nvl = m_vl;
        end else begin
            nvl = (avl < vlmax) ? int'(avl) : vlmax;
        end
        if (ill) begin
            nvl = 0;
        end
        top = (kind == VSETVL) ? 2'b10 : (kind == VSETIVLI) ? 2'b11 : 2'b00;

        @(posedge clk);
        #DRIVE_DLY;
        instruction_i           = {top, 4'b0, sew_raw, lmul_raw, rs1, 3'b111, rd, 7'h57};
        instruction_operation_i = kind;
        op1_scalar_i            = avl;
        op2_scalar_i            = {bad_bit, 25'b0, sew_raw, lmul_raw};
        @(negedge clk);
        check_value("vset vl", res_scalar_o, 32'(nvl));
        check_value("vset wr_en_scalar_o", {31'b0, wr_en_scalar_o}, 32'd1);
        check_value("vset hold_o", {31'b0, hold_o}, 32'd0);

        m_vl   = nvl;
        m_sew  = ns;
        m_lmul = nl;
        m_vill = ill;
    endtask

    task automatic shuffle_vtype();
        instr_class_e kind;
        int           sel;
        logic [2:0]   sew_raw;
        logic [2:0]   lmul_raw;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        sel      = rand16() % 3;
        kind     = (sel == 0) ? VSETVL : (sel == 1) ? VSETVLI : VSETIVLI;
        // Mostly legal vtypes with the odd reserved one
        sew_raw  = (rand16() % 16 == 0) ? 3'(3 + rand16() % 5) : 3'(rand16() % 3);
        lmul_raw = (rand16() % 16 == 0) ? 3'(4 + rand16() % 4) : 3'(rand16() % 4);
        rd       = (rand16() % 4 == 0) ? 5'd0 : 5'(1 + rand16() % 31);
        rs1      = (rand16() % 4 == 0) ? 5'd0 : 5'(1 + rand16() % 31);
        set_vtype(kind, rd, rs1, sew_raw, lmul_raw, 32'(rand16() % 40), rand16() % 10 == 0);
    endtask

    task automatic exec_vector(input vector_op_e op, input op_cat_e cat, input logic [4:0] vd,
                               input logic [4:0] vs2, input logic [4:0] vs1,
                               input logic [31:0] scalar);
        int          len;
        int          g;
        int          k;
        int          b;
        int          held;
        int          dst;
        int          elem;
        bit          done;
        logic [31:0] imm;
        logic [31:0] opb;
        logic [31:0] exp_res [8];
        len = 1 << m_lmul;
        if (op inside {V_SLL, V_SRL, V_SRA}) begin
            imm = {27'b0, vs1};
        end else begin
            imm = {{27{vs1[4]}}, vs1};
        end
        for (g = 0; g < len; g++) begin
            if (cat == OPIVV) begin
                opb = m_regs[(int'(vs1) + g) % 32];
            end else begin
                opb = replicate((cat == OPIVI) ? imm : scalar, m_sew);
            end
            exp_res[g] = alu_ref(op, m_regs[(int'(vs2) + g) % 32], opb, m_sew);
        end

        @(posedge clk);
        #DRIVE_DLY;
        instruction_i           = {6'b0, 1'b1, vs2, vs1, cat, vd, 7'h57};
        instruction_operation_i = VECTOR;
        vector_operation_i      = op;
        op1_scalar_i            = scalar;

        // Step g shows up in cycle k = g+2, which ends at E0+k
        k    = 0;
        held = 0;
        done = 0;
        while (!done) begin
            @(negedge clk);
            check_value("vector wr_en_scalar_o", {31'b0, wr_en_scalar_o}, 32'd0);
            if (k >= 2 && k - 2 < len) begin
                check_value("vector result", res_scalar_o, exp_res[k-2]);
            end
            if (hold_o) begin
                held++;
            end else begin
                done = 1;
            end
            k++;
            if (k > MAX_WAIT) begin
                fail_timeout("hold_o to drop");
            end
        end
        check_value("hold_o cycles", 32'(held), 32'(len + 1));

        // Body bytes only, tail and v0 keep their old value
        for (g = 0; g < len; g++) begin
            dst = (int'(vd) + g) % 32;
            for (b = 0; b < 4; b++) begin
                elem = g * (4 >> m_sew) + (b >> m_sew);
                if (dst != 0 && !m_vill && elem < m_vl) begin
                    m_regs[dst][b*8 +: 8] = exp_res[g][b*8 +: 8];
                end
            end
        end
    endtask

    task automatic issue_random_op();
        vector_op_e op;
        op_cat_e    cat;
        int         sel;
        int         start;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [4:0] vd;
        op    = vector_op_e'(1 + rand16() % 12);
        sel   = rand16() % 3;
        cat   = (sel == 0) ? OPIVV : (sel == 1) ? OPIVI : OPIVX;
        vs2   = 5'(rand16());
        vs1   = 5'(rand16());
        start = (rand16() % 8 == 0) ? 0 : rand16() % 32;
        vd    = pick_vd(vs2, vs1, cat == OPIVV, 1 << m_lmul, start);
        exec_vector(op, cat, vd, vs2, vs1, {rand16(), rand16()});
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        int n;
        clk                     = 1'b0;
        reset                   = 1'b1;
        instruction_i           = '0;
        instruction_operation_i = I_NONE;
        vector_operation_i      = V_NOP;
        op1_scalar_i            = '0;
        op2_scalar_i            = '0;
        lcg_state               = 32'd94;
        for (n = 0; n < NUM_VREGS; n++) begin
            m_regs[n] = '0;
        end
        m_vl   = 0;
        m_sew  = 0;
        m_lmul = 0;
        m_vill = 0;

        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(negedge clk);
        check_value("hold_o after reset", {31'b0, hold_o}, 32'd0);
        set_vtype(VSETVLI, 5'd0, 5'd0, 3'd0, 3'd0, 32'd7, 1'b0);

        // Seed v1..v31 from v0, one word per register
        set_vtype(VSETVLI, 5'd1, 5'd0, 3'd2, 3'd0, 32'd0, 1'b0);
        for (n = 1; n < NUM_VREGS; n++) begin
            exec_vector(V_ADD, OPIVX, 5'(n), 5'd0, 5'd0, {rand16(), rand16()});
        end

        // Tail bytes and v0
        set_vtype(VSETVLI, 5'd1, 5'd1, 3'd0, 3'd0, 32'd2, 1'b0);
        exec_vector(V_ADD, OPIVX, 5'd5, 5'd3, 5'd0, {rand16(), rand16()});
        set_vtype(VSETVLI, 5'd1, 5'd0, 3'd0, 3'd0, 32'd0, 1'b0);
        exec_vector(V_OR, OPIVV, 5'd7, 5'd5, 5'd5, 32'd0);
        exec_vector(V_XOR, OPIVI, 5'd0, 5'd4, 5'd9, 32'd0);
        exec_vector(V_OR, OPIVV, 5'd9, 5'd0, 5'd0, 32'd0);

        // Illegal vtype blocks all writes
        set_vtype(VSETVLI, 5'd1, 5'd1, 3'd3, 3'd0, 32'd5, 1'b0);
        exec_vector(V_ADD, OPIVX, 5'd6, 5'd2, 5'd0, {rand16(), rand16()});
        set_vtype(VSETVL, 5'd1, 5'd1, 3'd2, 3'd0, 32'd3, 1'b1);
        exec_vector(V_SUB, OPIVV, 5'd11, 5'd2, 5'd3, 32'd0);
        set_vtype(VSETVLI, 5'd1, 5'd0, 3'd0, 3'd1, 32'd0, 1'b0);
        exec_vector(V_OR, OPIVV, 5'd12, 5'd6, 5'd6, 32'd0);

        set_vtype(VSETIVLI, 5'd2, 5'd3, 3'd1, 3'd2, 32'd0, 1'b0);
        for (n = 0; n < NUM_RANDOM; n++) begin
            if (rand16() % 4 == 0) begin
                shuffle_vtype();
            end else begin
                issue_random_op();
            end
        end

        @(posedge clk);
        #DRIVE_DLY;
        instruction_operation_i = I_NONE;
        @(negedge clk);
        check_value("idle res_scalar_o", res_scalar_o, 32'd0);
        check_value("idle wr_en_scalar_o", {31'b0, wr_en_scalar_o}, 32'd0);
        check_value("idle hold_o", {31'b0, hold_o}, 32'd0);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: vlog.f
logic/vector_pkg.sv
logic/vector_ifs.sv
logic/vector_csr.sv
logic/vector_sequencer.sv
logic/vector_regfile.sv
logic/vector_alu.sv
logic/vector_unit.sv
dv/tb_vector_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_vector_unit \
        -f vlog.f -Mdir obj_dir -o tb_vector_unit \
    && ./obj_dir/tb_vector_unit \
    || { echo "simulation failed"; exit 1; }
